// ==== hdl/oled_bus_pkg.sv ====
package oled_bus_pkg;

	// one byte on the serial line
	typedef logic [7:0] byte_t;

	// data/command line levels
	localparam logic DC_CMD = 1'b0;
	localparam logic DC_DATA = 1'b1;

	// serial clock divisor, clk_in cycles per sclk period
	localparam logic [15:0] CLK_DIV_DEFAULT = 16'd20;

	// zero bytes written per page on clear
	localparam int CLEAR_BYTES = 128;

	localparam int BYTE_BITS = 8;  // bits per byte, msb first

endpackage

// ==== hdl/oled_font_pkg.sv ====
package oled_font_pkg;

	// glyph index or command row index
	typedef logic [6:0] glyph_code_t;

	// column within a glyph, 0 to 5
	typedef logic [2:0] col_idx_t;

	localparam int GLYPH_COLS = 6;  // column bytes per glyph

	// letter codes, kept at their font positions
	localparam glyph_code_t GC_COLON = 7'd26;
	localparam glyph_code_t GC_H = 7'd40;
	localparam glyph_code_t GC_V = 7'd54;
	localparam glyph_code_t GC_Z = 7'd58;
	localparam glyph_code_t GC_A = 7'd65;
	localparam glyph_code_t GC_D = 7'd68;
	localparam glyph_code_t GC_E = 7'd69;
	localparam glyph_code_t GC_F = 7'd70;
	localparam glyph_code_t GC_M = 7'd77;
	localparam glyph_code_t GC_P = 7'd80;
	localparam glyph_code_t GC_R = 7'd82;

	// digits use their own value as code, 0 to 9

	localparam int INIT_ROWS = 5;  // init rows are 0 to INIT_ROWS-1

	// page address command rows
	localparam glyph_code_t ROW_PAGE0 = 7'd5;
	localparam glyph_code_t ROW_PAGE1 = 7'd6;
	localparam glyph_code_t ROW_PAGE2 = 7'd7;
	localparam glyph_code_t ROW_PAGE3 = 7'd8;

endpackage

// ==== hdl/sclk_divider.sv ====
module sclk_divider #(
	parameter int CLK_DIV_PERIOD = int'(oled_bus_pkg::CLK_DIV_DEFAULT)
) (
	input  logic clk_in,
	input  logic rst_n_in,
	output logic sclk,
	output logic sclk_rise,
	output logic sclk_fall
);
	typedef enum logic [1:0] {EDGE_LOW, EDGE_RISE, EDGE_HIGH, EDGE_FALL} edge_t;

	logic [15:0] cnt_q;
	logic lvl_next;
	edge_t edge_q;

	assign lvl_next = (cnt_q >= 16'(CLK_DIV_PERIOD / 2));  // low for first half of count

	always_ff @(posedge clk_in or negedge rst_n_in) begin
		if (!rst_n_in) begin
			cnt_q <= '0;
			sclk <= 1'b0;
			edge_q <= EDGE_LOW;
		end else begin
			cnt_q <= (cnt_q == 16'(CLK_DIV_PERIOD - 1)) ? '0 : cnt_q + 16'd1;
			sclk <= lvl_next;
			// tracker follows the same next level, so strobes line up with sclk
			case (edge_q)
				EDGE_LOW: edge_q <= lvl_next ? EDGE_RISE : EDGE_LOW;
				EDGE_RISE: edge_q <= EDGE_HIGH;  // high lasts at least two cycles
				EDGE_HIGH: edge_q <= lvl_next ? EDGE_HIGH : EDGE_FALL;
				EDGE_FALL: edge_q <= EDGE_LOW;
				default: edge_q <= EDGE_LOW;
			endcase
		end
	end

	assign sclk_rise = (edge_q == EDGE_RISE);  // first cycle of sclk high
	assign sclk_fall = (edge_q == EDGE_FALL);  // first cycle of sclk low

endmodule

// ==== hdl/byte_serializer.sv ====
module byte_serializer (
	input  logic clk_in,
	input  logic rst_n_in,
	input  logic sclk_rise,
	input  logic sclk_fall,
	input  logic tx_start,
	input  oled_bus_pkg::byte_t tx_byte,
	output logic tx_done,
	output logic cs_n,
	output logic sdo
);
	localparam int MSB = oled_bus_pkg::BYTE_BITS - 1;
	localparam logic [3:0] LAST_BIT = 4'(oled_bus_pkg::BYTE_BITS);

	oled_bus_pkg::byte_t shift_q;
	logic busy_q;
	logic bit_out_q;  // bit on the line, waiting for the rising edge
	logic [3:0] bit_cnt_q;

	always_ff @(posedge clk_in) begin
		if (tx_start) begin
			shift_q <= tx_byte;
		end else if (busy_q && bit_out_q && sclk_rise) begin
			shift_q <= {shift_q[MSB-1:0], shift_q[MSB]};  // rotate left
		end
	end

	always_ff @(posedge clk_in or negedge rst_n_in) begin
		if (!rst_n_in) begin
			busy_q <= 1'b0;
			bit_out_q <= 1'b0;
			bit_cnt_q <= '0;
			tx_done <= 1'b0;
			cs_n <= 1'b1;
			sdo <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			if (tx_start) begin
				busy_q <= 1'b1;
				bit_out_q <= 1'b0;
				bit_cnt_q <= '0;
			end else if (busy_q) begin
				if (!bit_out_q && sclk_fall) begin
					if (bit_cnt_q == LAST_BIT) begin
						busy_q <= 1'b0;  // one extra fall closes the byte
						tx_done <= 1'b1;
						cs_n <= 1'b1;
					end else begin
						cs_n <= 1'b0;
						sdo <= shift_q[MSB];
						bit_out_q <= 1'b1;
					end
				end else if (bit_out_q && sclk_rise) begin
					bit_cnt_q <= bit_cnt_q + 4'd1;
					bit_out_q <= 1'b0;
				end
			end
		end
	end

endmodule

// ==== hdl/glyph_rom.sv ====
module glyph_rom (
	input  logic is_data,
	input  oled_font_pkg::glyph_code_t code,
	input  oled_font_pkg::col_idx_t col,
	output oled_bus_pkg::byte_t col_byte
);
	logic [47:0] row;  // six bytes, column 0 in the top byte

	always_comb begin
		row = '0;
		if (!is_data) begin
			case (code)
				7'd0: row = 48'hae_00_10_00_b0_81;  // init
				7'd1: row = 48'hff_a1_a6_a8_1f_c8;
				7'd2: row = 48'hd3_00_d5_80_d9_1f;
				7'd3: row = 48'hda_00_db_40_8d_14;
				7'd4: row = 48'haf_e3_e3_e3_e3_e3;  // display on, then nops
				7'd5: row = 48'hb0_01_10_e3_e3_e3;  // page 0
				7'd6: row = 48'hb1_01_10_e3_e3_e3;
				7'd7: row = 48'hb2_01_10_e3_e3_e3;
				7'd8: row = 48'hb3_01_10_e3_e3_e3;  // page 3
				default: row = '0;
			endcase
		end else begin
			case (code)
				7'd0: row = 48'h00_3e_51_49_45_3e;
				7'd1: row = 48'h00_00_42_7f_40_00;
				7'd2: row = 48'h00_42_61_51_49_46;
				7'd3: row = 48'h00_21_41_45_4b_31;
				7'd4: row = 48'h00_18_14_12_7f_10;
				7'd5: row = 48'h00_27_45_45_45_39;
				7'd6: row = 48'h00_3c_4a_49_49_30;
				7'd7: row = 48'h00_01_71_09_05_03;
				7'd8: row = 48'h00_36_49_49_49_36;
				7'd9: row = 48'h00_06_49_49_29_1e;
				oled_font_pkg::GC_COLON: row = 48'h00_00_36_36_00_00;
				oled_font_pkg::GC_H: row = 48'h00_7f_08_08_08_7f;
				oled_font_pkg::GC_V: row = 48'h00_1f_20_40_20_1f;
				oled_font_pkg::GC_Z: row = 48'h00_61_51_49_45_43;
				oled_font_pkg::GC_A: row = 48'h00_20_54_54_54_78;  // small letter shapes
				oled_font_pkg::GC_D: row = 48'h00_38_44_44_48_7f;
				oled_font_pkg::GC_E: row = 48'h00_38_54_54_54_18;
				oled_font_pkg::GC_F: row = 48'h00_08_7e_09_01_02;
				oled_font_pkg::GC_M: row = 48'h00_7c_04_18_04_78;
				oled_font_pkg::GC_P: row = 48'h00_fc_24_24_24_18;
				oled_font_pkg::GC_R: row = 48'h00_7c_08_04_04_08;
				default: row = '0;  // codes 10 to 15 from bad bcd land here
			endcase
		end
	end

	always_comb begin
		if (int'(col) < oled_font_pkg::GLYPH_COLS) begin
			col_byte = row[47 - 8 * int'(col) -: 8];
		end else begin
			col_byte = '0;
		end
	end

endmodule

// ==== hdl/oled_sequencer.sv ====
module oled_sequencer (
	input  logic clk_in,
	input  logic rst_n_in,
	input  logic [23:0] fre_bcd_in,
	input  logic [23:0] am_bcd_in,
	input  logic [23:0] phase_bcd_in,
	input  logic tx_done,
	input  oled_bus_pkg::byte_t col_byte,
	input  logic cs_n_ser,
	output logic tx_start,
	output oled_bus_pkg::byte_t tx_byte,
	output logic is_data,
	output oled_font_pkg::glyph_code_t code,
	output oled_font_pkg::col_idx_t col,
	output logic oled_rst_n_out,
	output logic oled_cs_n_out,
	output logic oled_dc_out
);
	localparam logic [5:0] STEP_RST_HIGH = 6'd2;
	localparam logic [5:0] STEP_INIT = 6'd3;
	localparam logic [5:0] STEP_INIT_LAST = STEP_INIT + 6'(oled_font_pkg::INIT_ROWS) - 6'd1;
	localparam logic [5:0] STEP_LOOP = 6'd16;  // page 0 command of the text loop
	localparam logic [5:0] STEP_LAST = 6'd53;  // "D" of RAD

	typedef enum logic [1:0] {ST_STEP, ST_SEND, ST_WAIT} state_t;

	state_t state_q;
	logic [5:0] step_q;
	logic [7:0] byte_cnt_q;
	logic [7:0] last_byte;
	logic clear_q;
	logic cs_gate_q;  // holds chip select high between bytes
	oled_font_pkg::glyph_code_t code_d;
	logic dc_d;
	logic clear_d;
	logic send_d;

	// nibble pos 0 is the leftmost digit
	function automatic oled_font_pkg::glyph_code_t digit_code(input logic [23:0] bcd,
			input logic [5:0] pos);
		logic [3:0] nib;
		nib = bcd[4 * (5 - int'(pos)) +: 4];
		return oled_font_pkg::glyph_code_t'(nib);
	endfunction

	always_comb begin
		send_d = (step_q > STEP_RST_HIGH);
		clear_d = step_q inside {6'd9, 6'd11, 6'd13, 6'd15};
		dc_d = (step_q inside {[STEP_INIT:6'd8], 6'd10, 6'd12, 6'd14, 6'd16, 6'd29, 6'd40}) ?
				oled_bus_pkg::DC_CMD : oled_bus_pkg::DC_DATA;
		case (step_q) inside
			[STEP_INIT:STEP_INIT_LAST]: code_d = oled_font_pkg::glyph_code_t'(step_q - STEP_INIT);
			6'd8, 6'd16: code_d = oled_font_pkg::ROW_PAGE0;
			6'd10, 6'd29: code_d = oled_font_pkg::ROW_PAGE1;
			6'd12, 6'd40: code_d = oled_font_pkg::ROW_PAGE2;
			6'd14: code_d = oled_font_pkg::ROW_PAGE3;
			6'd17: code_d = oled_font_pkg::GC_F;
			6'd18, 6'd51: code_d = oled_font_pkg::GC_R;
			6'd19: code_d = oled_font_pkg::GC_E;
			6'd20, 6'd32, 6'd44: code_d = oled_font_pkg::GC_COLON;
			[6'd21:6'd26]: code_d = digit_code(fre_bcd_in, step_q - 6'd21);
			6'd27, 6'd42: code_d = oled_font_pkg::GC_H;
			6'd28: code_d = oled_font_pkg::GC_Z;
			6'd30, 6'd43, 6'd52: code_d = oled_font_pkg::GC_A;
			6'd31: code_d = oled_font_pkg::GC_M;
			[6'd33:6'd38]: code_d = digit_code(am_bcd_in, step_q - 6'd33);
			6'd39: code_d = oled_font_pkg::GC_V;
			6'd41: code_d = oled_font_pkg::GC_P;
			[6'd45:6'd50]: code_d = digit_code(phase_bcd_in, step_q - 6'd45);
			6'd53: code_d = oled_font_pkg::GC_D;
			default: code_d = '0;  // reset and clear steps
		endcase
	end

	assign last_byte = clear_q ? 8'(oled_bus_pkg::CLEAR_BYTES - 1) :
			8'(oled_font_pkg::GLYPH_COLS - 1);

	always_ff @(posedge clk_in or negedge rst_n_in) begin
		if (!rst_n_in) begin
			state_q <= ST_STEP;
			step_q <= '0;
			byte_cnt_q <= '0;
			clear_q <= 1'b0;
			code <= '0;
			cs_gate_q <= 1'b1;
			tx_start <= 1'b0;
			oled_rst_n_out <= 1'b0;
			oled_dc_out <= oled_bus_pkg::DC_CMD;
		end else begin
			tx_start <= 1'b0;
			case (state_q)
				ST_STEP: begin
					if (step_q == STEP_RST_HIGH) begin
						oled_rst_n_out <= 1'b1;  // release panel reset
					end
					code <= code_d;  // digits sampled here
					oled_dc_out <= dc_d;
					clear_q <= clear_d;
					byte_cnt_q <= '0;
					if (send_d) begin
						state_q <= ST_SEND;
					end else begin
						step_q <= step_q + 6'd1;
					end
				end
				ST_SEND: begin
					tx_start <= 1'b1;
					cs_gate_q <= 1'b0;
					state_q <= ST_WAIT;
				end
				ST_WAIT: begin
					if (tx_done) begin
						cs_gate_q <= 1'b1;
						byte_cnt_q <= byte_cnt_q + 8'd1;
						if (byte_cnt_q == last_byte) begin
							state_q <= ST_STEP;
							step_q <= (step_q == STEP_LAST) ? STEP_LOOP : step_q + 6'd1;
						end else begin
							state_q <= ST_SEND;
						end
					end
				end
				default: state_q <= ST_STEP;
			endcase
		end
	end

	assign is_data = (oled_dc_out == oled_bus_pkg::DC_DATA);
	assign col = oled_font_pkg::col_idx_t'(byte_cnt_q[2:0]);
	assign tx_byte = clear_q ? '0 : col_byte;  // clear sends zero columns
	assign oled_cs_n_out = cs_n_ser | cs_gate_q;

endmodule

// ==== hdl/oled_display_top.sv ====
module oled_display_top #(
	parameter int CLK_DIV_PERIOD = int'(oled_bus_pkg::CLK_DIV_DEFAULT)
) (
	input  logic clk_in,
	input  logic rst_n_in,
	input  logic [23:0] fre_bcd_in,
	input  logic [23:0] am_bcd_in,
	input  logic [23:0] phase_bcd_in,
	output logic oled_rst_n_out,
	output logic oled_cs_n_out,
	output logic oled_dc_out,
	output logic oled_clk_out,
	output logic oled_data_out
);
	logic sclk_rise;
	logic sclk_fall;
	logic tx_start;
	logic tx_done;
	logic cs_n_ser;  // serializer frame, gated by the sequencer
	logic is_data;
	oled_bus_pkg::byte_t tx_byte;
	oled_bus_pkg::byte_t col_byte;
	oled_font_pkg::glyph_code_t code;
	oled_font_pkg::col_idx_t col;

	sclk_divider #(
		.CLK_DIV_PERIOD(CLK_DIV_PERIOD)
	) sclk_divider_i (
		.clk_in(clk_in),
		.rst_n_in(rst_n_in),
		.sclk(oled_clk_out),
		.sclk_rise(sclk_rise),
		.sclk_fall(sclk_fall)
	);

	byte_serializer byte_serializer_i (
		.clk_in(clk_in),
		.rst_n_in(rst_n_in),
		.sclk_rise(sclk_rise),
		.sclk_fall(sclk_fall),
		.tx_start(tx_start),
		.tx_byte(tx_byte),
		.tx_done(tx_done),
		.cs_n(cs_n_ser),
		.sdo(oled_data_out)
	);

	glyph_rom glyph_rom_i (
		.is_data(is_data),
		.code(code),
		.col(col),
		.col_byte(col_byte)
	);

	oled_sequencer oled_sequencer_i (
		.clk_in(clk_in),
		.rst_n_in(rst_n_in),
		.fre_bcd_in(fre_bcd_in),
		.am_bcd_in(am_bcd_in),
		.phase_bcd_in(phase_bcd_in),
		.tx_done(tx_done),
		.col_byte(col_byte),
		.cs_n_ser(cs_n_ser),
		.tx_start(tx_start),
		.tx_byte(tx_byte),
		.is_data(is_data),
		.code(code),
		.col(col),
		.oled_rst_n_out(oled_rst_n_out),
		.oled_cs_n_out(oled_cs_n_out),
		.oled_dc_out(oled_dc_out)
	);

endmodule

// ==== verif/oled_display_properties.sv ====
module oled_display_properties (
	input logic clk_in,
	input logic rst_n_in,
	input logic oled_cs_n_out,
	input logic oled_dc_out,
	input logic oled_clk_out,
	input logic oled_data_out
);
	timeunit 1ns;
	timeprecision 1ps;

	// panel samples data on the rising serial clock
	data_stable_a: assert property (@(negedge clk_in) disable iff (!rst_n_in)
			oled_clk_out && !oled_cs_n_out |-> $stable(oled_data_out))
		else $error("serial data changed while the serial clock was high");

	cs_reset_a: assert property (@(negedge clk_in) !rst_n_in |-> oled_cs_n_out)
		else $error("chip select low during reset");

	dc_stable_a: assert property (@(negedge clk_in) disable iff (!rst_n_in)
			!oled_cs_n_out |-> $stable(oled_dc_out))
		else $error("data/command level changed inside a byte");

endmodule

bind oled_display_top oled_display_properties oled_display_properties_i (
	.clk_in(clk_in),
	.rst_n_in(rst_n_in),
	.oled_cs_n_out(oled_cs_n_out),
	.oled_dc_out(oled_dc_out),
	.oled_clk_out(oled_clk_out),
	.oled_data_out(oled_data_out)
);

// ==== verif/oled_display_tb.sv ====
module oled_display_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_DIV_PERIOD = 4;
	localparam int CLK_PERIOD_NS = 40;
	localparam int NUM_ROWS = 4;  // one frame checked per stimulus row
	localparam int FRAME_BYTES = 228;  // three lines of 78, 66 and 84 bytes
	localparam int START_BYTES = 30 + 4 * (6 + oled_bus_pkg::CLEAR_BYTES);
	localparam int LIMIT_NS = 2 * (START_BYTES + NUM_ROWS * FRAME_BYTES) * 8 *
			CLK_DIV_PERIOD * CLK_PERIOD_NS;

	logic clk_in;
	logic rst_n_in;
	logic [23:0] fre_bcd_in;
	logic [23:0] am_bcd_in;
	logic [23:0] phase_bcd_in;
	logic oled_rst_n_out;
	logic oled_cs_n_out;
	logic oled_dc_out;
	logic oled_clk_out;
	logic oled_data_out;

	logic [23:0] stim_tab [NUM_ROWS][3];  // fre, am, phase bcd per row
	logic [8:0] rx_q [$];  // dc level above the byte
	logic [7:0] rx_shift;
	logic sclk_prev;
	int rx_bits;
	int byte_idx;
	int value_errors;
	int other_errors;

	oled_display_top #(
		.CLK_DIV_PERIOD(CLK_DIV_PERIOD)
	) oled_display_top_i (.*);

	initial begin
		clk_in = 1'b0;
		forever #(CLK_PERIOD_NS / 2) clk_in = ~clk_in;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [47:0] cmd_row(input int row);
		case (row)
			0: return 48'hae_00_10_00_b0_81;
			1: return 48'hff_a1_a6_a8_1f_c8;
			2: return 48'hd3_00_d5_80_d9_1f;
			3: return 48'hda_00_db_40_8d_14;
			4: return 48'haf_e3_e3_e3_e3_e3;
			default: return {8'hb0 + 8'(row - 5), 40'h01_10_e3_e3_e3};  // page address rows
		endcase
	endfunction

	function automatic logic [47:0] font_cols(input byte ch);
		case (ch)
			"0": return 48'h00_3e_51_49_45_3e;
			"1": return 48'h00_00_42_7f_40_00;
			"2": return 48'h00_42_61_51_49_46;
			"3": return 48'h00_21_41_45_4b_31;
			"4": return 48'h00_18_14_12_7f_10;
			"5": return 48'h00_27_45_45_45_39;
			"6": return 48'h00_3c_4a_49_49_30;
			"7": return 48'h00_01_71_09_05_03;
			"8": return 48'h00_36_49_49_49_36;
			"9": return 48'h00_06_49_49_29_1e;
			":": return 48'h00_00_36_36_00_00;
			"H": return 48'h00_7f_08_08_08_7f;
			"V": return 48'h00_1f_20_40_20_1f;
			"Z": return 48'h00_61_51_49_45_43;
			"A": return 48'h00_20_54_54_54_78;
			"D": return 48'h00_38_44_44_48_7f;
			"E": return 48'h00_38_54_54_54_18;
			"F": return 48'h00_08_7e_09_01_02;
			"M": return 48'h00_7c_04_18_04_78;
			"P": return 48'h00_fc_24_24_24_18;
			"R": return 48'h00_7c_08_04_04_08;
			default: return '0;
		endcase
	endfunction

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error: %s expected %h got %h", name, exp, got);
			value_errors++;
		end
	endtask

	task automatic expect_byte(input logic [7:0] exp_byte, input logic exp_dc);
		logic [8:0] got;
		while (rx_q.size() == 0) begin
			@(negedge clk_in);
		end
		got = rx_q.pop_front();
		if (got[7:0] !== exp_byte) begin
			$display("Error: oled_data_out byte %0d expected %h got %h", byte_idx, exp_byte, got[7:0]);
			value_errors++;
		end
		if (got[8] !== exp_dc) begin
			$display("Error: oled_dc_out byte %0d expected %h got %h", byte_idx, exp_dc, got[8]);
			value_errors++;
		end
		byte_idx++;
	endtask

	task automatic check_row(input logic [47:0] cols, input logic dc);
		for (int i = 0; i < oled_font_pkg::GLYPH_COLS; i++) begin
			expect_byte(cols[47 - 8 * i -: 8], dc);  // column 0 first
		end
	endtask

	task automatic check_text(input string s);
		for (int i = 0; i < s.len(); i++) begin
			check_row(font_cols(s[i]), oled_bus_pkg::DC_DATA);
		end
	endtask

	task automatic apply_row(input int r);
		fre_bcd_in = stim_tab[r][0];
		am_bcd_in = stim_tab[r][1];
		phase_bcd_in = stim_tab[r][2];
	endtask

	// serial bus decoder, sampled mid-cycle
	always @(negedge clk_in) begin : decode_bus
		logic [7:0] next_shift;
		if (rst_n_in && oled_clk_out && !sclk_prev && !oled_cs_n_out) begin
			next_shift = {rx_shift[6:0], oled_data_out};  // msb arrives first
			if (rx_bits == 7) begin
				rx_q.push_back({oled_dc_out, next_shift});
				rx_bits = 0;
			end else begin
				rx_bits++;
			end
			rx_shift = next_shift;
		end else if (oled_cs_n_out && rx_bits != 0) begin
			$display("Chip select went high in the middle of byte %0d", byte_idx);
			other_errors++;
			rx_bits = 0;
		end
		sclk_prev = oled_clk_out;
	end

	initial begin : main_flow
		logic [31:0] seed;
		int low_cycles;
		seed = 32'h2c504c15;
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int f = 0; f < 3; f++) begin
				for (int d = 0; d < 6; d++) begin
					seed = lcg_next(seed);
					stim_tab[r][f][4 * (5 - d) +: 4] = 4'((seed >> 16) % 10);
				end
			end
		end
		rx_shift = '0;
		sclk_prev = 1'b0;
		rx_bits = 0;
		byte_idx = 0;
		value_errors = 0;
		other_errors = 0;
		rst_n_in = 1'b0;
		apply_row(0);
		repeat (3) begin
			@(negedge clk_in);
			check_level("oled_rst_n_out", oled_rst_n_out, 1'b0);
			check_level("oled_cs_n_out", oled_cs_n_out, 1'b1);
			check_level("oled_dc_out", oled_dc_out, oled_bus_pkg::DC_CMD);
			check_level("oled_data_out", oled_data_out, 1'b0);
			check_level("oled_clk_out", oled_clk_out, 1'b0);
		end
		rst_n_in = 1'b1;
		low_cycles = 0;
		while (oled_rst_n_out !== 1'b1) begin
			@(negedge clk_in);
			low_cycles++;
		end
		if (low_cycles < 2) begin
			$display("Panel reset was released after only %0d cycles", low_cycles);
			other_errors++;
		end
		if (rx_q.size() != 0 || rx_bits != 0) begin
			$display("Bytes were sent before the panel reset was released");
			other_errors++;
		end
		for (int row = 0; row < oled_font_pkg::INIT_ROWS; row++) begin
			check_row(cmd_row(row), oled_bus_pkg::DC_CMD);
		end
		for (int p = 0; p < 4; p++) begin
			check_row(cmd_row(5 + p), oled_bus_pkg::DC_CMD);
			repeat (oled_bus_pkg::CLEAR_BYTES) expect_byte(8'h00, oled_bus_pkg::DC_DATA);
		end
		for (int r = 0; r < NUM_ROWS; r++) begin
			check_row(cmd_row(5), oled_bus_pkg::DC_CMD);
			check_text($sformatf("FRE:%hHZ", stim_tab[r][0]));  // bcd prints as digits
			check_row(cmd_row(6), oled_bus_pkg::DC_CMD);
			check_text($sformatf("AM:%hV", stim_tab[r][1]));
			check_row(cmd_row(7), oled_bus_pkg::DC_CMD);
			check_text($sformatf("PHA:%hRAD", stim_tab[r][2]));
			if (r + 1 < NUM_ROWS) begin
				apply_row(r + 1);  // after the last byte of the frame
			end
		end
		$display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin : watchdog
		#(LIMIT_NS);
		$display("Timeout after %0d ns with %0d bytes checked", LIMIT_NS, byte_idx);
		$display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
		$display("Errors found");
		$finish;
	end

endmodule

// ==== oled_display_top.f ====
hdl/oled_bus_pkg.sv
hdl/oled_font_pkg.sv
hdl/sclk_divider.sv
hdl/byte_serializer.sv
hdl/glyph_rom.sv
hdl/oled_sequencer.sv
hdl/oled_display_top.sv
verif/oled_display_properties.sv
verif/oled_display_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the OLED testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module oled_display_tb -f oled_display_top.f \
	-o oled_display_sim \
	&& ./obj_dir/oled_display_sim | tee sim.log \
	|| { echo "build or simulation failed"; exit 1; }
grep -q "^No errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
